// File: Makefile
VERILATOR ?= verilator
TOP ?= core_tb
OBJ_DIR ?= obj_dir
FILELIST ?= sim.f
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= All tests passed

SRCS := $(shell cat $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output.
run: $(BIN)
	./$(BIN) | awk '{ print } /^$(PASS_TEXT)$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// File: sim.f
src/core_pkg.sv
src/fetch_unit.sv
src/control_fsm.sv
src/immediate_gen.sv
src/regfile.sv
src/execute_unit.sv
src/result_unit.sv
src/core_top.sv
verification/tb_memory.sv
verification/core_tb.sv

// File: src/control_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module control_fsm (
	input  wire logic                   clk_i,
	input  wire logic                   reset_i,
	input  wire core_pkg::instruction_t instr_i,
	output logic                        imem_re_o,
	output logic                        ir_we_o,
	output logic                        pc_we_o,
	output logic                        regfile_we_o,
	output logic                        dmem_re_o,
	output logic                        dmem_we_o,
	output core_pkg::mem_size_t         mem_size_o,
	output logic                        load_unsigned_o,
	output core_pkg::next_pc_sel_t      next_pc_sel_o,
	output core_pkg::wb_sel_t           wb_sel_o,
	output core_pkg::alu_op_t           alu_op_o,
	output core_pkg::alu_in1_sel_t      alu_in1_sel_o,
	output core_pkg::alu_in2_sel_t      alu_in2_sel_o,
	output core_pkg::cmp_op_t           cmp_op_o,
	output logic                        halted_o,
	output logic                        trap_o
);
	localparam logic [2:0] S_FETCH   = 3'd0;
	localparam logic [2:0] S_DECODE  = 3'd1;
	localparam logic [2:0] S_EXECUTE = 3'd2;
	localparam logic [2:0] S_LOAD_WB = 3'd3;
	localparam logic [2:0] S_HALT    = 3'd4;

	logic [2:0] state;
	logic [2:0] state_next;
	logic legal;
	logic is_ebreak;
	logic is_load;
	logic is_store;
	logic writes_rd;

	function automatic core_pkg::alu_op_t alu_from_funct(input logic [2:0] f3, input logic alt);
		case (f3)
		3'b000:  return alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
		3'b001:  return core_pkg::ALU_SLL;
		3'b010:  return core_pkg::ALU_SLT;
		3'b011:  return core_pkg::ALU_SLTU;
		3'b100:  return core_pkg::ALU_XOR;
		3'b101:  return alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
		3'b110:  return core_pkg::ALU_OR;
		default: return core_pkg::ALU_AND;
		endcase
	endfunction

	// ********************
	// instruction decode.
	// ********************
	always_comb begin
		legal = 1'b1;
		is_ebreak = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		writes_rd = 1'b1;
		next_pc_sel_o = core_pkg::NEXT_PC_PLUS4;
		wb_sel_o = core_pkg::WB_ALU;
		alu_op_o = core_pkg::ALU_ADD;
		alu_in1_sel_o = core_pkg::ALU_IN1_REG;
		alu_in2_sel_o = core_pkg::ALU_IN2_IMM;
		case (instr_i.r.opcode)
		core_pkg::OP_LUI: alu_op_o = core_pkg::ALU_PASS2;
		core_pkg::OP_AUIPC: alu_in1_sel_o = core_pkg::ALU_IN1_PC;
		core_pkg::OP_JAL: begin
			alu_in1_sel_o = core_pkg::ALU_IN1_PC;
			next_pc_sel_o = core_pkg::NEXT_PC_ALU;
			wb_sel_o = core_pkg::WB_PC4;
		end
		core_pkg::OP_JALR: begin
			next_pc_sel_o = core_pkg::NEXT_PC_ALU;
			wb_sel_o = core_pkg::WB_PC4;
		end
		core_pkg::OP_BRANCH: begin
			// target is pc + imm, taken only if the compare holds.
			alu_in1_sel_o = core_pkg::ALU_IN1_PC;
			next_pc_sel_o = core_pkg::NEXT_PC_CMP;
			writes_rd = 1'b0;
			legal = instr_i.b.funct3[2:1] != 2'b01;
		end
		core_pkg::OP_LOAD: begin
			is_load = 1'b1;
			wb_sel_o = core_pkg::WB_LOAD;
			legal = instr_i.i.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
		end
		core_pkg::OP_STORE: begin
			is_store = 1'b1;
			writes_rd = 1'b0;
			legal = instr_i.s.funct3 inside {3'b000, 3'b001, 3'b010};
		end
		core_pkg::OP_IMM: begin
			// only the shift-right immediate uses the funct7 bit.
			alu_op_o = alu_from_funct(instr_i.i.funct3,
				instr_i.i.funct3 == 3'b101 && instr_i.r.funct7[5]);
		end
		core_pkg::OP_REG: begin
			alu_in2_sel_o = core_pkg::ALU_IN2_REG;
			alu_op_o = alu_from_funct(instr_i.r.funct3, instr_i.r.funct7[5]);
		end
		core_pkg::OP_SYSTEM: begin
			// ebreak only, everything else in this space traps.
			writes_rd = 1'b0;
			is_ebreak = instr_i.i.imm == 12'h001;
			legal = is_ebreak;
		end
		default: begin
			writes_rd = 1'b0;
			legal = 1'b0;
		end
		endcase
	end

	always_comb begin
		case (instr_i.b.funct3)
		3'b001:  cmp_op_o = core_pkg::CMP_NE;
		3'b100:  cmp_op_o = core_pkg::CMP_LT;
		3'b101:  cmp_op_o = core_pkg::CMP_GE;
		3'b110:  cmp_op_o = core_pkg::CMP_LTU;
		3'b111:  cmp_op_o = core_pkg::CMP_GEU;
		default: cmp_op_o = core_pkg::CMP_EQ;
		endcase
		case (instr_i.i.funct3[1:0])
		2'b00:   mem_size_o = core_pkg::MEM_BYTE;
		2'b01:   mem_size_o = core_pkg::MEM_HALF;
		default: mem_size_o = core_pkg::MEM_WORD;
		endcase
		load_unsigned_o = instr_i.i.funct3[2];
	end

	// ********************
	// sequencer.
	// ********************
	always_comb begin
		imem_re_o = 1'b0;
		ir_we_o = 1'b0;
		pc_we_o = 1'b0;
		regfile_we_o = 1'b0;
		dmem_re_o = 1'b0;
		dmem_we_o = 1'b0;
		state_next = state;
		case (state)
		S_FETCH: begin
			imem_re_o = 1'b1;
			state_next = S_DECODE;
		end
		S_DECODE: begin
			ir_we_o = 1'b1;
			state_next = S_EXECUTE;
		end
		S_EXECUTE: begin
			if (is_ebreak || !legal) begin
				state_next = S_HALT;
			end else if (is_load) begin
				dmem_re_o = 1'b1;
				state_next = S_LOAD_WB;
			end else begin
				dmem_we_o = is_store;
				regfile_we_o = writes_rd;
				pc_we_o = 1'b1;
				state_next = S_FETCH;
			end
		end
		S_LOAD_WB: begin
			regfile_we_o = 1'b1;
			pc_we_o = 1'b1;
			state_next = S_FETCH;
		end
		default: state_next = S_HALT;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state <= S_FETCH;
			halted_o <= 1'b0;
			trap_o <= 1'b0;
		end else begin
			state <= state_next;
			if (state == S_EXECUTE && is_ebreak) begin
				halted_o <= 1'b1;
			end
			if (state == S_EXECUTE && !legal) begin
				trap_o <= 1'b1;
			end
		end
	end

	dmem_rw_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
		!(dmem_re_o && dmem_we_o))
		else $error("data read and write strobes together");

	// once stopped, the core stays quiet until reset.
	halt_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
		(halted_o || trap_o) |-> !(imem_re_o || dmem_re_o || dmem_we_o
			|| regfile_we_o || pc_we_o))
		else $error("strobe fired while halted");
endmodule

`default_nettype wire

// File: src/core_pkg.sv
`default_nettype none

package core_pkg;

	// ********************
	// base opcodes.
	// ********************
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	// ********************
	// datapath selects.
	// ********************
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS2
	} alu_op_t;

	typedef enum logic {ALU_IN1_REG, ALU_IN1_PC} alu_in1_sel_t;

	typedef enum logic {ALU_IN2_REG, ALU_IN2_IMM} alu_in2_sel_t;

	typedef enum logic [2:0] {
		CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU
	} cmp_op_t;

	typedef enum logic [1:0] {NEXT_PC_PLUS4, NEXT_PC_ALU, NEXT_PC_CMP} next_pc_sel_t;

	typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_LOAD} wb_sel_t;

	// encoded like funct3[1:0] of loads and stores.
	typedef enum logic [1:0] {MEM_BYTE = 2'b00, MEM_HALF = 2'b01, MEM_WORD = 2'b10} mem_size_t;

	// ********************
	// instruction formats.
	// ********************
	typedef union packed {
		struct packed {
			logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
			logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm; logic [4:0] rs1;
			logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;
		} i;
		struct packed {
			logic [6:0] imm11_5; logic [4:0] rs2; logic [4:0] rs1;
			logic [2:0] funct3; logic [4:0] imm4_0; logic [6:0] opcode;
		} s;
		struct packed {
			logic imm12; logic [5:0] imm10_5; logic [4:0] rs2; logic [4:0] rs1;
			logic [2:0] funct3; logic [3:0] imm4_1; logic imm11; logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm31_12; logic [4:0] rd; logic [6:0] opcode;
		} u;
		struct packed {
			logic imm20; logic [9:0] imm10_1; logic imm11; logic [7:0] imm19_12;
			logic [4:0] rd; logic [6:0] opcode;
		} j;
	} instruction_t;

endpackage

`default_nettype wire

// File: src/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top #(
	parameter logic [31:0] RESET_PC = 32'h0001_0000
) (
	input  wire logic        clk_i,
	input  wire logic        reset_i,
	output logic             imem_re_o,
	output logic [31:0]      imem_addr_o,
	input  wire logic [31:0] imem_rdata_i,
	output logic             dmem_re_o,
	output logic             dmem_we_o,
	output logic [31:0]      dmem_addr_o,
	output logic [31:0]      dmem_wdata_o,
	output logic [3:0]       dmem_be_o,
	input  wire logic [31:0] dmem_rdata_i,
	output logic             halted_o,
	output logic             trap_o
);
	// fetch.
	core_pkg::instruction_t instr;
	logic [31:0] pc;
	logic [31:0] pc_plus4;

	// control.
	logic ctrl_ir_we;
	logic ctrl_pc_we;
	logic ctrl_regfile_we;
	logic ctrl_load_unsigned;
	core_pkg::mem_size_t ctrl_mem_size;
	core_pkg::next_pc_sel_t ctrl_next_pc_sel;
	core_pkg::wb_sel_t ctrl_wb_sel;
	core_pkg::alu_op_t ctrl_alu_op;
	core_pkg::alu_in1_sel_t ctrl_alu_in1_sel;
	core_pkg::alu_in2_sel_t ctrl_alu_in2_sel;
	core_pkg::cmp_op_t ctrl_cmp_op;

	// datapath.
	logic [31:0] imm;
	logic [31:0] rf_rout1;
	logic [31:0] rf_rout2;
	logic [31:0] rf_rin;
	logic [31:0] alu_out;
	logic cmp_res;

	assign imem_addr_o = pc;

	fetch_unit #(.RESET_PC(RESET_PC)) u_fetch_unit (
		.clk_i(clk_i), .reset_i(reset_i),
		.pc_we_i(ctrl_pc_we), .ir_we_i(ctrl_ir_we),
		.next_pc_sel_i(ctrl_next_pc_sel), .cmp_res_i(cmp_res),
		.alu_out_i(alu_out), .imem_rdata_i(imem_rdata_i),
		.pc_o(pc), .pc_plus4_o(pc_plus4), .instr_o(instr)
	);

	control_fsm u_control_fsm (
		.clk_i(clk_i), .reset_i(reset_i), .instr_i(instr),
		.imem_re_o(imem_re_o), .ir_we_o(ctrl_ir_we), .pc_we_o(ctrl_pc_we),
		.regfile_we_o(ctrl_regfile_we), .dmem_re_o(dmem_re_o), .dmem_we_o(dmem_we_o),
		.mem_size_o(ctrl_mem_size), .load_unsigned_o(ctrl_load_unsigned),
		.next_pc_sel_o(ctrl_next_pc_sel), .wb_sel_o(ctrl_wb_sel),
		.alu_op_o(ctrl_alu_op), .alu_in1_sel_o(ctrl_alu_in1_sel),
		.alu_in2_sel_o(ctrl_alu_in2_sel), .cmp_op_o(ctrl_cmp_op),
		.halted_o(halted_o), .trap_o(trap_o)
	);

	immediate_gen u_immediate_gen (.instr_i(instr), .imm_o(imm));

	regfile u_regfile (
		.clk_i(clk_i),
		.rs1_i(instr.r.rs1), .rs2_i(instr.r.rs2), .rd_i(instr.r.rd),
		.rin_i(rf_rin), .we_i(ctrl_regfile_we),
		.rout1_o(rf_rout1), .rout2_o(rf_rout2)
	);

	execute_unit u_execute_unit (
		.alu_op_i(ctrl_alu_op), .alu_in1_sel_i(ctrl_alu_in1_sel),
		.alu_in2_sel_i(ctrl_alu_in2_sel), .cmp_op_i(ctrl_cmp_op),
		.mem_size_i(ctrl_mem_size), .pc_i(pc),
		.rs1_data_i(rf_rout1), .rs2_data_i(rf_rout2), .imm_i(imm),
		.alu_out_o(alu_out), .cmp_res_o(cmp_res), .dmem_addr_o(dmem_addr_o),
		.dmem_wdata_o(dmem_wdata_o), .dmem_be_o(dmem_be_o)
	);

	result_unit u_result_unit (
		.wb_sel_i(ctrl_wb_sel), .mem_size_i(ctrl_mem_size),
		.load_unsigned_i(ctrl_load_unsigned), .addr_low_i(alu_out[1:0]),
		.alu_out_i(alu_out), .pc_plus4_i(pc_plus4), .dmem_rdata_i(dmem_rdata_i),
		.rin_o(rf_rin)
	);
endmodule

`default_nettype wire

// File: src/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input  wire core_pkg::alu_op_t      alu_op_i,
	input  wire core_pkg::alu_in1_sel_t alu_in1_sel_i,
	input  wire core_pkg::alu_in2_sel_t alu_in2_sel_i,
	input  wire core_pkg::cmp_op_t      cmp_op_i,
	input  wire core_pkg::mem_size_t    mem_size_i,
	input  wire logic [31:0]            pc_i,
	input  wire logic [31:0]            rs1_data_i,
	input  wire logic [31:0]            rs2_data_i,
	input  wire logic [31:0]            imm_i,
	output logic [31:0]                 alu_out_o,
	output logic                        cmp_res_o,
	output logic [31:0]                 dmem_addr_o,
	output logic [31:0]                 dmem_wdata_o,
	output logic [3:0]                  dmem_be_o
);
	logic [31:0] in1;
	logic [31:0] in2;

	assign in1 = (alu_in1_sel_i == core_pkg::ALU_IN1_PC) ? pc_i : rs1_data_i;
	assign in2 = (alu_in2_sel_i == core_pkg::ALU_IN2_IMM) ? imm_i : rs2_data_i;

	// ********************
	// alu.
	// ********************
	always_comb begin
		case (alu_op_i)
		core_pkg::ALU_SUB:   alu_out_o = in1 - in2;
		core_pkg::ALU_SLL:   alu_out_o = in1 << in2[4:0];
		core_pkg::ALU_SLT:   alu_out_o = {31'd0, $signed(in1) < $signed(in2)};
		core_pkg::ALU_SLTU:  alu_out_o = {31'd0, in1 < in2};
		core_pkg::ALU_XOR:   alu_out_o = in1 ^ in2;
		core_pkg::ALU_SRL:   alu_out_o = in1 >> in2[4:0];
		core_pkg::ALU_SRA:   alu_out_o = $unsigned($signed(in1) >>> in2[4:0]);
		core_pkg::ALU_OR:    alu_out_o = in1 | in2;
		core_pkg::ALU_AND:   alu_out_o = in1 & in2;
		core_pkg::ALU_PASS2: alu_out_o = in2;
		default:             alu_out_o = in1 + in2;
		endcase
	end

	// branch compare always works on the two register operands.
	always_comb begin
		case (cmp_op_i)
		core_pkg::CMP_NE:  cmp_res_o = rs1_data_i != rs2_data_i;
		core_pkg::CMP_LT:  cmp_res_o = $signed(rs1_data_i) < $signed(rs2_data_i);
		core_pkg::CMP_GE:  cmp_res_o = $signed(rs1_data_i) >= $signed(rs2_data_i);
		core_pkg::CMP_LTU: cmp_res_o = rs1_data_i < rs2_data_i;
		core_pkg::CMP_GEU: cmp_res_o = rs1_data_i >= rs2_data_i;
		default:           cmp_res_o = rs1_data_i == rs2_data_i;
		endcase
	end

	// ********************
	// store lanes.
	// ********************
	assign dmem_addr_o = {alu_out_o[31:2], 2'b00};

	always_comb begin
		case (mem_size_i)
		core_pkg::MEM_BYTE: begin
			dmem_wdata_o = {4{rs2_data_i[7:0]}};
			dmem_be_o = 4'b0001 << alu_out_o[1:0];
		end
		core_pkg::MEM_HALF: begin
			dmem_wdata_o = {2{rs2_data_i[15:0]}};
			dmem_be_o = 4'b0011 << {alu_out_o[1], 1'b0};
		end
		default: begin
			dmem_wdata_o = rs2_data_i;
			dmem_be_o = 4'b1111;
		end
		endcase
	end
endmodule

`default_nettype wire

// File: src/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
	parameter logic [31:0] RESET_PC = 32'h0001_0000
) (
	input  wire logic                   clk_i,
	input  wire logic                   reset_i,
	input  wire logic                   pc_we_i,
	input  wire logic                   ir_we_i,
	input  wire core_pkg::next_pc_sel_t next_pc_sel_i,
	input  wire logic                   cmp_res_i,
	input  wire logic [31:0]            alu_out_i,
	input  wire logic [31:0]            imem_rdata_i,
	output logic [31:0]                 pc_o,
	output logic [31:0]                 pc_plus4_o,
	output core_pkg::instruction_t      instr_o
);
	logic [31:0] pc;
	logic [31:0] next_pc;
	core_pkg::instruction_t ir;

	assign pc_o = pc;
	assign pc_plus4_o = pc + 32'd4;
	assign instr_o = ir;

	always_comb begin
		case (next_pc_sel_i)
		// jalr clears bit 0 of the target.
		core_pkg::NEXT_PC_ALU: next_pc = {alu_out_i[31:1], 1'b0};
		core_pkg::NEXT_PC_CMP: next_pc = cmp_res_i ? alu_out_i : pc_plus4_o;
		default:               next_pc = pc_plus4_o;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pc <= RESET_PC;
			ir <= '0;
		end else begin
			if (pc_we_i) begin
				pc <= next_pc;
			end
			if (ir_we_i) begin
				ir <= imem_rdata_i;
			end
		end
	end

	pc_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
		pc_we_i |=> (pc[1:0] == 2'b00))
		else $error("pc left word alignment: %h", pc);
endmodule

`default_nettype wire

// File: src/immediate_gen.sv
`timescale 1ns/1ps
`default_nettype none

module immediate_gen (
	input  wire core_pkg::instruction_t instr_i,
	output logic [31:0]                 imm_o
);
	always_comb begin
		case (instr_i.r.opcode)
		core_pkg::OP_LUI, core_pkg::OP_AUIPC: begin
			imm_o = {instr_i.u.imm31_12, 12'b0};
		end
		core_pkg::OP_JAL: begin
			imm_o = {{12{instr_i.j.imm20}}, instr_i.j.imm19_12, instr_i.j.imm11,
				instr_i.j.imm10_1, 1'b0};
		end
		core_pkg::OP_BRANCH: begin
			imm_o = {{20{instr_i.b.imm12}}, instr_i.b.imm11, instr_i.b.imm10_5,
				instr_i.b.imm4_1, 1'b0};
		end
		core_pkg::OP_STORE: begin
			imm_o = {{20{instr_i.s.imm11_5[6]}}, instr_i.s.imm11_5, instr_i.s.imm4_0};
		end
		// jalr, loads, alu immediates and system.
		default: begin
			imm_o = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
		end
		endcase
	end
endmodule

`default_nettype wire

// File: src/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  wire logic        clk_i,
	input  wire logic [4:0]  rs1_i,
	input  wire logic [4:0]  rs2_i,
	input  wire logic [4:0]  rd_i,
	input  wire logic [31:0] rin_i,
	input  wire logic        we_i,
	output logic [31:0]      rout1_o,
	output logic [31:0]      rout2_o
);
	logic [31:0] regs [32];

	// x0 reads as zero whatever the array holds.
	assign rout1_o = (rs1_i == 5'd0) ? 32'd0 : regs[rs1_i];
	assign rout2_o = (rs2_i == 5'd0) ? 32'd0 : regs[rs2_i];

	always_ff @(posedge clk_i) begin
		if (we_i && rd_i != 5'd0) begin
			regs[rd_i] <= rin_i;
		end
	end
endmodule

`default_nettype wire

// File: src/result_unit.sv
`timescale 1ns/1ps
`default_nettype none

module result_unit (
	input  wire core_pkg::wb_sel_t   wb_sel_i,
	input  wire core_pkg::mem_size_t mem_size_i,
	input  wire logic                load_unsigned_i,
	input  wire logic [1:0]          addr_low_i,
	input  wire logic [31:0]         alu_out_i,
	input  wire logic [31:0]         pc_plus4_i,
	input  wire logic [31:0]         dmem_rdata_i,
	output logic [31:0]              rin_o
);
	logic [31:0] shifted;
	logic [31:0] load_data;
	logic sign_fill;

	// bring the addressed lane down to bit 0.
	assign shifted = dmem_rdata_i >> {addr_low_i, 3'b000};

	always_comb begin
		sign_fill = 1'b0;
		case (mem_size_i)
		core_pkg::MEM_BYTE: begin
			sign_fill = shifted[7] & ~load_unsigned_i;
			load_data = {{24{sign_fill}}, shifted[7:0]};
		end
		core_pkg::MEM_HALF: begin
			sign_fill = shifted[15] & ~load_unsigned_i;
			load_data = {{16{sign_fill}}, shifted[15:0]};
		end
		default: load_data = dmem_rdata_i;
		endcase
	end

	always_comb begin
		case (wb_sel_i)
		core_pkg::WB_PC4:  rin_o = pc_plus4_i;
		core_pkg::WB_LOAD: rin_o = load_data;
		default:           rin_o = alu_out_i;
		endcase
	end
endmodule

`default_nettype wire

// File: verification/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;
	localparam logic [31:0] RESET_PC = 32'h0001_0000;
	localparam logic [31:0] EBREAK = 32'h0010_0073;
	localparam logic [31:0] RESULT_BASE = 32'h0000_0400;
	localparam int RUN_LIMIT = 2000;

	logic clk_i;
	logic reset_i;
	logic imem_re;
	logic [31:0] imem_addr;
	logic [31:0] imem_rdata;
	logic dmem_re;
	logic dmem_we;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic [3:0] dmem_be;
	logic [31:0] dmem_rdata;
	logic halted;
	logic trap;

	logic [31:0] prog [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [3:0] exp_be [$];
	int slot;
	int errors;
	int tests_run;
	int tests_failed;

	core_top #(.RESET_PC(RESET_PC)) u_core_top (
		.clk_i(clk_i), .reset_i(reset_i),
		.imem_re_o(imem_re), .imem_addr_o(imem_addr), .imem_rdata_i(imem_rdata),
		.dmem_re_o(dmem_re), .dmem_we_o(dmem_we), .dmem_addr_o(dmem_addr),
		.dmem_wdata_o(dmem_wdata), .dmem_be_o(dmem_be), .dmem_rdata_i(dmem_rdata),
		.halted_o(halted), .trap_o(trap)
	);

	tb_memory u_mem (
		.clk_i(clk_i),
		.imem_re_i(imem_re), .imem_addr_i(imem_addr), .imem_rdata_o(imem_rdata),
		.dmem_re_i(dmem_re), .dmem_we_i(dmem_we), .dmem_addr_i(dmem_addr),
		.dmem_wdata_i(dmem_wdata), .dmem_be_i(dmem_be), .dmem_rdata_o(dmem_rdata)
	);

	always #20 clk_i = ~clk_i;

	// ********************
	// instruction encoding.
	// ********************
	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs1, logic [4:0] rs2,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] next_pc_value();
		return RESET_PC + 32'(prog.size() * 4);
	endfunction

	task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] hi;
		hi = (value + 32'h800) >> 12;
		prog.push_back({hi[19:0], rd, 7'b0110111});
		prog.push_back(enc_i(value[11:0], rd, 3'b000, rd, 7'b0010011));
	endtask

	// sw into the next result slot and expect the given word there.
	task automatic store_result(input logic [4:0] rs, input logic [31:0] value);
		logic [31:0] addr;
		addr = RESULT_BASE + 32'(slot * 4);
		prog.push_back(enc_s(addr[11:0], rs, 5'd0, 3'b010));
		exp_addr.push_back(addr);
		exp_data.push_back(value);
		exp_be.push_back(4'b1111);
		slot++;
	endtask

	// ********************
	// reference rules.
	// ********************
	function automatic logic [31:0] model_alu(logic [2:0] f3, logic alt, logic [31:0] a,
		logic [31:0] b);
		case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << b[4:0];
		3'd2: return {31'd0, $signed(a) < $signed(b)};
		3'd3: return {31'd0, a < b};
		3'd4: return a ^ b;
		3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'd6: return a | b;
		default: return a & b;
		endcase
	endfunction

	function automatic logic model_branch(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		case (f3)
		3'd0: return a == b;
		3'd1: return a != b;
		3'd4: return $signed(a) < $signed(b);
		3'd5: return $signed(a) >= $signed(b);
		3'd6: return a < b;
		default: return a >= b;
		endcase
	endfunction

	// ********************
	// run control.
	// ********************
	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic start_test();
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
		exp_be.delete();
		slot = 0;
		for (int i = 0; i < 1024; i++) begin
			u_mem.dmem[i] = 32'h5A5A_0000 ^ (i * 4);
		end
	endtask

	task automatic run_program(input logic expect_trap);
		int cycles;
		@(posedge clk_i);
		#1 reset_i = 1'b1;
		for (int i = 0; i < prog.size(); i++) begin
			u_mem.imem[((RESET_PC >> 2) + i) % 1024] = prog[i];
		end
		u_mem.st_addr.delete();
		u_mem.st_data.delete();
		u_mem.st_be.delete();
		repeat (5) @(posedge clk_i);
		#1 reset_i = 1'b0;
		// the first fetch comes straight out of reset.
		@(negedge clk_i);
		check_word("imem_re_o", 32'(imem_re), 32'd1);
		check_word("imem_addr_o", imem_addr, RESET_PC);
		cycles = 1;
		while (!(halted || trap) && cycles < RUN_LIMIT) begin
			@(negedge clk_i);
			cycles++;
		end
		assert (halted || trap) else begin
			$display("core did not stop within %0d cycles", RUN_LIMIT);
			errors++;
		end
		check_word("trap_o", 32'(trap), 32'(expect_trap));
		check_word("halted_o", 32'(halted), 32'(!expect_trap));
	endtask

	task automatic check_stores();
		check_word("store count", 32'(u_mem.st_addr.size()), 32'(exp_addr.size()));
		for (int i = 0; i < exp_addr.size() && i < u_mem.st_addr.size(); i++) begin
			check_word($sformatf("dmem_addr_o[%0d]", i), u_mem.st_addr[i], exp_addr[i]);
			check_word($sformatf("dmem_wdata_o[%0d]", i), u_mem.st_data[i], exp_data[i]);
			check_word($sformatf("dmem_be_o[%0d]", i), 32'(u_mem.st_be[i]), 32'(exp_be[i]));
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", name, errors - errors_before);
		end
	endtask

	// ********************
	// directed tests.
	// ********************
	task automatic test_alu();
		int e0;
		logic [31:0] a;
		logic [31:0] b;
		logic [11:0] imm;
		logic [2:0] f3;
		logic [2:0] imm_ops [9];
		logic alt;
		e0 = errors;
		start_test();
		// addi, slti, sltiu, xori, ori, andi, slli, srli, srai.
		imm_ops = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
		a = $urandom();
		b = $urandom();
		load_const(5'd1, a);
		load_const(5'd2, b);
		for (int k = 0; k < 10; k++) begin
			f3 = (k < 2) ? 3'd0 : (k < 7) ? 3'(k - 1) : (k == 7) ? 3'd5 : 3'(k - 2);
			alt = (k == 1) || (k == 7);
			prog.push_back(enc_r(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3));
			store_result(5'd3, model_alu(f3, alt, a, b));
		end
		for (int k = 0; k < 9; k++) begin
			f3 = imm_ops[k];
			alt = (k == 8);
			imm = 12'($urandom());
			if (f3 == 3'd1 || f3 == 3'd5) begin
				imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
			end
			prog.push_back(enc_i(imm, 5'd1, f3, 5'd3, 7'b0010011));
			store_result(5'd3, model_alu(f3, alt, a, {{20{imm[11]}}, imm}));
		end
		prog.push_back(EBREAK);
		run_program(1'b0);
		check_stores();
		finish_test("alu", e0);
	endtask

	task automatic test_upper_and_jumps();
		int e0;
		logic [19:0] up;
		logic [31:0] pc;
		e0 = errors;
		start_test();
		up = 20'($urandom());
		prog.push_back({up, 5'd3, 7'b0110111});
		store_result(5'd3, {up, 12'd0});
		pc = next_pc_value();
		prog.push_back({up, 5'd4, 7'b0010111});
		store_result(5'd4, pc + {up, 12'd0});
		// jal skips one store that must never reach the bus.
		pc = next_pc_value();
		prog.push_back(enc_j(21'd8, 5'd5));
		prog.push_back(enc_s(12'h500, 5'd1, 5'd0, 3'b010));
		store_result(5'd5, pc + 32'd4);
		pc = next_pc_value();
		prog.push_back({20'd0, 5'd6, 7'b0010111});
		prog.push_back(enc_i(12'd12, 5'd6, 3'b000, 5'd7, 7'b1100111));
		prog.push_back(enc_s(12'h504, 5'd1, 5'd0, 3'b010));
		store_result(5'd7, pc + 32'd8);
		prog.push_back(EBREAK);
		run_program(1'b0);
		check_stores();
		finish_test("upper immediates and jumps", e0);
	endtask

	task automatic test_branches();
		int e0;
		int n;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] x;
		logic [31:0] y;
		logic [2:0] types [6];
		logic taken;
		e0 = errors;
		start_test();
		types = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		n = 0;
		for (int t = 0; t < 6; t++) begin
			a = $urandom();
			b = $urandom();
			if (b == a) begin
				b = ~a;
			end
			// (a,b), (b,a) and (a,a) give both outcomes for every compare.
			for (int p = 0; p < 3; p++) begin
				x = (p == 1) ? b : a;
				y = (p == 0) ? b : a;
				taken = model_branch(types[t], x, y);
				load_const(5'd1, x);
				load_const(5'd2, y);
				prog.push_back(enc_b(13'd12, 5'd1, 5'd2, types[t]));
				prog.push_back(enc_i(12'(n * 2), 5'd0, 3'b000, 5'd3, 7'b0010011));
				prog.push_back(enc_j(21'd8, 5'd0));
				prog.push_back(enc_i(12'(n * 2 + 1), 5'd0, 3'b000, 5'd3, 7'b0010011));
				store_result(5'd3, 32'(n * 2) + 32'(taken));
				n++;
			end
		end
		prog.push_back(EBREAK);
		run_program(1'b0);
		check_stores();
		finish_test("branches", e0);
	endtask

	task automatic test_loads();
		int e0;
		logic [31:0] words [4];
		logic [31:0] w;
		logic [31:0] lane;
		logic [11:0] addr;
		e0 = errors;
		start_test();
		for (int i = 0; i < 4; i++) begin
			words[i] = $urandom();
			u_mem.dmem[(12'h200 >> 2) + i] = words[i];
		end
		for (int off = 0; off < 4; off++) begin
			w = words[off];
			addr = 12'h200 + 12'(off * 4) + 12'(off);
			lane = w >> (off * 8);
			prog.push_back(enc_i(addr, 5'd0, 3'b000, 5'd3, 7'b0000011));
			store_result(5'd3, {{24{lane[7]}}, lane[7:0]});
			prog.push_back(enc_i(addr, 5'd0, 3'b100, 5'd3, 7'b0000011));
			store_result(5'd3, {24'd0, lane[7:0]});
			if (off[0] == 1'b0) begin
				prog.push_back(enc_i(addr, 5'd0, 3'b001, 5'd3, 7'b0000011));
				store_result(5'd3, {{16{lane[15]}}, lane[15:0]});
				prog.push_back(enc_i(addr, 5'd0, 3'b101, 5'd3, 7'b0000011));
				store_result(5'd3, {16'd0, lane[15:0]});
			end
			if (off == 0) begin
				prog.push_back(enc_i(addr, 5'd0, 3'b010, 5'd3, 7'b0000011));
				store_result(5'd3, w);
			end
		end
		prog.push_back(EBREAK);
		run_program(1'b0);
		check_stores();
		finish_test("loads", e0);
	endtask

	task automatic test_stores();
		int e0;
		logic [31:0] v;
		e0 = errors;
		start_test();
		v = $urandom();
		load_const(5'd1, v);
		for (int off = 0; off < 4; off++) begin
			prog.push_back(enc_s(12'h300 + 12'(off), 5'd1, 5'd0, 3'b000));
			exp_addr.push_back(32'h300);
			exp_data.push_back({4{v[7:0]}});
			exp_be.push_back(4'b0001 << off);
		end
		for (int off = 0; off < 4; off += 2) begin
			prog.push_back(enc_s(12'h304 + 12'(off), 5'd1, 5'd0, 3'b001));
			exp_addr.push_back(32'h304);
			exp_data.push_back({2{v[15:0]}});
			exp_be.push_back(4'b0011 << off);
		end
		prog.push_back(enc_s(12'h308, 5'd1, 5'd0, 3'b010));
		exp_addr.push_back(32'h308);
		exp_data.push_back(v);
		exp_be.push_back(4'b1111);
		prog.push_back(enc_i(12'd123, 5'd0, 3'b000, 5'd0, 7'b0010011));
		store_result(5'd0, 32'd0);
		prog.push_back(EBREAK);
		run_program(1'b0);
		check_stores();
		finish_test("stores", e0);
	endtask

	task automatic test_halt_and_trap();
		int e0;
		int strobes;
		e0 = errors;
		start_test();
		load_const(5'd1, 32'h1234_5678);
		store_result(5'd1, 32'h1234_5678);
		prog.push_back(EBREAK);
		prog.push_back(enc_s(12'h600, 5'd1, 5'd0, 3'b010));
		run_program(1'b0);
		strobes = 0;
		for (int c = 0; c < 20; c++) begin
			@(negedge clk_i);
			strobes += int'(imem_re) + int'(dmem_re) + int'(dmem_we);
		end
		check_word("strobes after ebreak", 32'(strobes), 32'd0);
		check_stores();
		start_test();
		load_const(5'd1, 32'hCAFE_0042);
		store_result(5'd1, 32'hCAFE_0042);
		prog.push_back(32'hFFFF_FFFF);
		prog.push_back(enc_s(12'h600, 5'd1, 5'd0, 3'b010));
		prog.push_back(EBREAK);
		run_program(1'b1);
		repeat (10) @(negedge clk_i);
		check_stores();
		finish_test("halt and trap", e0);
	endtask

	initial begin
		clk_i = 1'b0;
		reset_i = 1'b1;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(12));
		test_alu();
		test_upper_and_jumps();
		test_branches();
		test_loads();
		test_stores();
		test_halt_and_trap();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end
endmodule

`default_nettype wire

// File: verification/tb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memory (
	input  wire logic        clk_i,
	input  wire logic        imem_re_i,
	input  wire logic [31:0] imem_addr_i,
	output logic [31:0]      imem_rdata_o,
	input  wire logic        dmem_re_i,
	input  wire logic        dmem_we_i,
	input  wire logic [31:0] dmem_addr_i,
	input  wire logic [31:0] dmem_wdata_i,
	input  wire logic [3:0]  dmem_be_i,
	output logic [31:0]      dmem_rdata_o
);
	// 4 KiB each, addressed by word and wrapping.
	logic [31:0] imem [1024];
	logic [31:0] dmem [1024];

	// every store seen on the bus, in order.
	logic [31:0] st_addr [$];
	logic [31:0] st_data [$];
	logic [3:0] st_be [$];

	initial begin
		imem_rdata_o = '0;
		dmem_rdata_o = '0;
	end

	always @(posedge clk_i) begin
		if (imem_re_i) begin
			imem_rdata_o <= imem[imem_addr_i[11:2]];
		end
		if (dmem_re_i) begin
			dmem_rdata_o <= dmem[dmem_addr_i[11:2]];
		end
	end

	always @(posedge clk_i) begin
		if (dmem_we_i) begin
			for (int b = 0; b < 4; b++) begin
				if (dmem_be_i[b]) begin
					dmem[dmem_addr_i[11:2]][b*8 +: 8] <= dmem_wdata_i[b*8 +: 8];
				end
			end
			st_addr.push_back(dmem_addr_i);
			st_data.push_back(dmem_wdata_i);
			st_be.push_back(dmem_be_i);
		end
	end
endmodule

`default_nettype wire
